// File: common/tl_pkg.sv
// TL-UL bus widths, opcode encodings and RAM geometry shared by all blocks
`default_nettype none

package tl_pkg;

  ////////////////////////////////////////
  // Data path
  ////////////////////////////////////////

  // One word per beat, no bursts
  localparam int unsigned DataWidth = 32;
  localparam int unsigned DataBytes = DataWidth / 8;

  ////////////////////////////////////////
  // Addressing
  ////////////////////////////////////////

  // Byte address as seen on the A channel
  localparam int unsigned AddrWidth = 32;

  // Word index into the 1024-word RAM
  localparam int unsigned BramAddrWidth = 10;

  // Byte-in-word bits dropped before the RAM index
  localparam int unsigned WordOffset = $clog2(DataBytes);

  ////////////////////////////////////////
  // Source and size fields
  ////////////////////////////////////////

  localparam int unsigned HostSourceWidth = 4;

  // Device side carries one extra bit naming the host
  localparam int unsigned DevSourceWidth = HostSourceWidth + 1;

  localparam int unsigned SizeWidth = 3;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // A channel, TL-UL encodings
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel, TL-UL encodings
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

endpackage

`default_nettype wire

// File: hw/bram_sp.sv
// Single-port synchronous RAM with per-byte write mask and registered read
`timescale 1ns/1ps
`default_nettype none

module bram_sp (
  input  wire logic                             clk_i,
  input  wire logic                             en_i,
  input  wire logic                             we_i,
  input  wire logic [tl_pkg::BramAddrWidth-1:0] addr_i,
  input  wire logic [tl_pkg::DataBytes-1:0]     wmask_i,
  input  wire logic [tl_pkg::DataWidth-1:0]     wdata_i,
  output logic      [tl_pkg::DataWidth-1:0]     rdata_o
);

  localparam int unsigned Depth = 2 ** tl_pkg::BramAddrWidth;

  logic [tl_pkg::DataWidth-1:0] mem_q [Depth];
  logic [tl_pkg::DataWidth-1:0] rdata_q;

  // Byte lanes written under mask
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      for (int unsigned b = 0; b < tl_pkg::DataBytes; b++) begin
        if (wmask_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read-first, so a write cycle returns the old word
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  // Output holds until the next enabled access
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hw/tl_adapter_bram.sv
// TL-UL device that drives a single-port BRAM, one response per request
`timescale 1ns/1ps
`default_nettype none

module tl_adapter_bram (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,

  // A channel from the arbiter
  input  wire logic                              a_valid_i,
  input  wire tl_pkg::tl_a_op_e                  a_opcode_i,
  input  wire logic [tl_pkg::SizeWidth-1:0]      a_size_i,
  input  wire logic [tl_pkg::DevSourceWidth-1:0] a_source_i,
  input  wire logic [tl_pkg::AddrWidth-1:0]      a_address_i,
  input  wire logic [tl_pkg::DataBytes-1:0]      a_mask_i,
  input  wire logic [tl_pkg::DataWidth-1:0]      a_data_i,
  output logic                                   a_ready_o,

  // D channel back to the arbiter
  output logic                                   d_valid_o,
  output tl_pkg::tl_d_op_e                       d_opcode_o,
  output logic      [tl_pkg::SizeWidth-1:0]      d_size_o,
  output logic      [tl_pkg::DevSourceWidth-1:0] d_source_o,
  output logic      [tl_pkg::DataWidth-1:0]      d_data_o,
  input  wire logic                              d_ready_i,

  // RAM port
  output logic                                   bram_en_o,
  output logic                                   bram_we_o,
  output logic      [tl_pkg::BramAddrWidth-1:0]  bram_addr_o,
  output logic      [tl_pkg::DataBytes-1:0]      bram_wmask_o,
  output logic      [tl_pkg::DataWidth-1:0]      bram_wdata_o,
  input  wire logic [tl_pkg::DataWidth-1:0]      bram_rdata_i
);

  logic                              a_fire;
  logic                              d_valid_q;
  tl_pkg::tl_d_op_e                  d_opcode_q;
  logic [tl_pkg::SizeWidth-1:0]      d_size_q;
  logic [tl_pkg::DevSourceWidth-1:0] d_source_q;

  ////////////////////////////////////////
  // Request handshake
  ////////////////////////////////////////

  // Accept while the response slot is empty or draining this cycle
  assign a_ready_o = !d_valid_q || d_ready_i;
  assign a_fire    = a_valid_i && a_ready_o;

  ////////////////////////////////////////
  // RAM access
  ////////////////////////////////////////

  assign bram_en_o    = a_fire;
  // Both Put flavours write, the mask picks the lanes
  assign bram_we_o    = a_opcode_i != tl_pkg::Get;
  assign bram_addr_o  = a_address_i[tl_pkg::WordOffset +: tl_pkg::BramAddrWidth];
  assign bram_wmask_o = a_mask_i;
  assign bram_wdata_o = a_data_i;

  ////////////////////////////////////////
  // Response slot
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_valid_q <= 1'b0;
    end else if (a_fire) begin
      d_valid_q <= 1'b1;
    end else if (d_ready_i) begin
      d_valid_q <= 1'b0;
    end
  end

  // Echoed fields, loaded together with the RAM access
  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      d_opcode_q <= (a_opcode_i == tl_pkg::Get) ? tl_pkg::AccessAckData : tl_pkg::AccessAck;
      d_size_q   <= a_size_i;
      d_source_q <= a_source_i;
    end
  end

  assign d_valid_o  = d_valid_q;
  assign d_opcode_o = d_opcode_q;
  assign d_size_o   = d_size_q;
  assign d_source_o = d_source_q;

  // RAM output stays put while stalled, no new access can start
  assign d_data_o   = bram_rdata_i;

endmodule

`default_nettype wire

// File: hw/tl_host_arb.sv
// Two-host round-robin TL-UL arbiter with source tagging and response routing
`timescale 1ns/1ps
`default_nettype none

module tl_host_arb (
  input  wire logic                               clk_i,
  input  wire logic                               rst_ni,

  // Host 0 A channel
  input  wire logic                               h0_a_valid_i,
  input  wire tl_pkg::tl_a_op_e                   h0_a_opcode_i,
  input  wire logic [tl_pkg::SizeWidth-1:0]       h0_a_size_i,
  input  wire logic [tl_pkg::HostSourceWidth-1:0] h0_a_source_i,
  input  wire logic [tl_pkg::AddrWidth-1:0]       h0_a_address_i,
  input  wire logic [tl_pkg::DataBytes-1:0]       h0_a_mask_i,
  input  wire logic [tl_pkg::DataWidth-1:0]       h0_a_data_i,
  output logic                                    h0_a_ready_o,

  // Host 0 D channel
  output logic                                    h0_d_valid_o,
  output tl_pkg::tl_d_op_e                        h0_d_opcode_o,
  output logic      [tl_pkg::SizeWidth-1:0]       h0_d_size_o,
  output logic      [tl_pkg::HostSourceWidth-1:0] h0_d_source_o,
  output logic      [tl_pkg::DataWidth-1:0]       h0_d_data_o,
  input  wire logic                               h0_d_ready_i,

  // Host 1 A channel
  input  wire logic                               h1_a_valid_i,
  input  wire tl_pkg::tl_a_op_e                   h1_a_opcode_i,
  input  wire logic [tl_pkg::SizeWidth-1:0]       h1_a_size_i,
  input  wire logic [tl_pkg::HostSourceWidth-1:0] h1_a_source_i,
  input  wire logic [tl_pkg::AddrWidth-1:0]       h1_a_address_i,
  input  wire logic [tl_pkg::DataBytes-1:0]       h1_a_mask_i,
  input  wire logic [tl_pkg::DataWidth-1:0]       h1_a_data_i,
  output logic                                    h1_a_ready_o,

  // Host 1 D channel
  output logic                                    h1_d_valid_o,
  output tl_pkg::tl_d_op_e                        h1_d_opcode_o,
  output logic      [tl_pkg::SizeWidth-1:0]       h1_d_size_o,
  output logic      [tl_pkg::HostSourceWidth-1:0] h1_d_source_o,
  output logic      [tl_pkg::DataWidth-1:0]       h1_d_data_o,
  input  wire logic                               h1_d_ready_i,

  // Device A channel
  output logic                                    dev_a_valid_o,
  output tl_pkg::tl_a_op_e                        dev_a_opcode_o,
  output logic      [tl_pkg::SizeWidth-1:0]       dev_a_size_o,
  output logic      [tl_pkg::DevSourceWidth-1:0]  dev_a_source_o,
  output logic      [tl_pkg::AddrWidth-1:0]       dev_a_address_o,
  output logic      [tl_pkg::DataBytes-1:0]       dev_a_mask_o,
  output logic      [tl_pkg::DataWidth-1:0]       dev_a_data_o,
  input  wire logic                               dev_a_ready_i,

  // Device D channel
  input  wire logic                               dev_d_valid_i,
  input  wire tl_pkg::tl_d_op_e                   dev_d_opcode_i,
  input  wire logic [tl_pkg::SizeWidth-1:0]       dev_d_size_i,
  input  wire logic [tl_pkg::DevSourceWidth-1:0]  dev_d_source_i,
  input  wire logic [tl_pkg::DataWidth-1:0]       dev_d_data_i,
  output logic                                    dev_d_ready_o
);

  localparam int unsigned TagBit = tl_pkg::DevSourceWidth - 1;

  // 1 means host 1 won the last completed transfer
  logic last_q;
  // 1 selects host 1 for this cycle
  logic sel;
  logic d_tag;

  ////////////////////////////////////////
  // Grant
  ////////////////////////////////////////

  // Host 1 wins if alone, or on a tie when host 0 won last
  assign sel = h1_a_valid_i && (!h0_a_valid_i || !last_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Host 0 takes the first tie
      last_q <= 1'b1;
    end else if (dev_a_valid_o && dev_a_ready_i) begin
      last_q <= sel;
    end
  end

  ////////////////////////////////////////
  // Request forwarding
  ////////////////////////////////////////

  assign dev_a_valid_o   = h0_a_valid_i || h1_a_valid_i;
  assign dev_a_opcode_o  = sel ? h1_a_opcode_i  : h0_a_opcode_i;
  assign dev_a_size_o    = sel ? h1_a_size_i    : h0_a_size_i;
  assign dev_a_address_o = sel ? h1_a_address_i : h0_a_address_i;
  assign dev_a_mask_o    = sel ? h1_a_mask_i    : h0_a_mask_i;
  assign dev_a_data_o    = sel ? h1_a_data_i    : h0_a_data_i;

  // Host number goes into the top source bit
  assign dev_a_source_o  = sel ? {1'b1, h1_a_source_i} : {1'b0, h0_a_source_i};

  assign h0_a_ready_o = !sel && dev_a_ready_i;
  assign h1_a_ready_o = sel && dev_a_ready_i;

  ////////////////////////////////////////
  // Response routing
  ////////////////////////////////////////

  assign d_tag = dev_d_source_i[TagBit];

  assign h0_d_valid_o = dev_d_valid_i && !d_tag;
  assign h1_d_valid_o = dev_d_valid_i && d_tag;
  assign dev_d_ready_o = d_tag ? h1_d_ready_i : h0_d_ready_i;

  // Payload is shared, only valid tells the hosts apart
  assign h0_d_opcode_o = dev_d_opcode_i;
  assign h0_d_size_o   = dev_d_size_i;
  assign h0_d_source_o = dev_d_source_i[TagBit-1:0];
  assign h0_d_data_o   = dev_d_data_i;

  assign h1_d_opcode_o = dev_d_opcode_i;
  assign h1_d_size_o   = dev_d_size_i;
  assign h1_d_source_o = dev_d_source_i[TagBit-1:0];
  assign h1_d_data_o   = dev_d_data_i;

endmodule

`default_nettype wire

// File: hw/tl_mem_top.sv
// Two-host TL-UL memory: arbiter, BRAM adapter and single-port RAM
`timescale 1ns/1ps
`default_nettype none

module tl_mem_top (
  input  wire logic                               clk_i,
  input  wire logic                               rst_ni,

  // Host 0
  input  wire logic                               h0_a_valid_i,
  input  wire tl_pkg::tl_a_op_e                   h0_a_opcode_i,
  input  wire logic [tl_pkg::SizeWidth-1:0]       h0_a_size_i,
  input  wire logic [tl_pkg::HostSourceWidth-1:0] h0_a_source_i,
  input  wire logic [tl_pkg::AddrWidth-1:0]       h0_a_address_i,
  input  wire logic [tl_pkg::DataBytes-1:0]       h0_a_mask_i,
  input  wire logic [tl_pkg::DataWidth-1:0]       h0_a_data_i,
  output logic                                    h0_a_ready_o,
  output logic                                    h0_d_valid_o,
  output tl_pkg::tl_d_op_e                        h0_d_opcode_o,
  output logic      [tl_pkg::SizeWidth-1:0]       h0_d_size_o,
  output logic      [tl_pkg::HostSourceWidth-1:0] h0_d_source_o,
  output logic      [tl_pkg::DataWidth-1:0]       h0_d_data_o,
  input  wire logic                               h0_d_ready_i,

  // Host 1
  input  wire logic                               h1_a_valid_i,
  input  wire tl_pkg::tl_a_op_e                   h1_a_opcode_i,
  input  wire logic [tl_pkg::SizeWidth-1:0]       h1_a_size_i,
  input  wire logic [tl_pkg::HostSourceWidth-1:0] h1_a_source_i,
  input  wire logic [tl_pkg::AddrWidth-1:0]       h1_a_address_i,
  input  wire logic [tl_pkg::DataBytes-1:0]       h1_a_mask_i,
  input  wire logic [tl_pkg::DataWidth-1:0]       h1_a_data_i,
  output logic                                    h1_a_ready_o,
  output logic                                    h1_d_valid_o,
  output tl_pkg::tl_d_op_e                        h1_d_opcode_o,
  output logic      [tl_pkg::SizeWidth-1:0]       h1_d_size_o,
  output logic      [tl_pkg::HostSourceWidth-1:0] h1_d_source_o,
  output logic      [tl_pkg::DataWidth-1:0]       h1_d_data_o,
  input  wire logic                               h1_d_ready_i
);

  ////////////////////////////////////////
  // Device-side TL-UL
  ////////////////////////////////////////

  logic                              dev_a_valid;
  tl_pkg::tl_a_op_e                  dev_a_opcode;
  logic [tl_pkg::SizeWidth-1:0]      dev_a_size;
  logic [tl_pkg::DevSourceWidth-1:0] dev_a_source;
  logic [tl_pkg::AddrWidth-1:0]      dev_a_address;
  logic [tl_pkg::DataBytes-1:0]      dev_a_mask;
  logic [tl_pkg::DataWidth-1:0]      dev_a_data;
  logic                              dev_a_ready;
  logic                              dev_d_valid;
  tl_pkg::tl_d_op_e                  dev_d_opcode;
  logic [tl_pkg::SizeWidth-1:0]      dev_d_size;
  logic [tl_pkg::DevSourceWidth-1:0] dev_d_source;
  logic [tl_pkg::DataWidth-1:0]      dev_d_data;
  logic                              dev_d_ready;

  // RAM port
  logic                              bram_en;
  logic                              bram_we;
  logic [tl_pkg::BramAddrWidth-1:0]  bram_addr;
  logic [tl_pkg::DataBytes-1:0]      bram_wmask;
  logic [tl_pkg::DataWidth-1:0]      bram_wdata;
  logic [tl_pkg::DataWidth-1:0]      bram_rdata;

  tl_host_arb u_arb (
    .clk_i, .rst_ni,
    .h0_a_valid_i, .h0_a_opcode_i, .h0_a_size_i, .h0_a_source_i,
    .h0_a_address_i, .h0_a_mask_i, .h0_a_data_i, .h0_a_ready_o,
    .h0_d_valid_o, .h0_d_opcode_o, .h0_d_size_o, .h0_d_source_o,
    .h0_d_data_o, .h0_d_ready_i,
    .h1_a_valid_i, .h1_a_opcode_i, .h1_a_size_i, .h1_a_source_i,
    .h1_a_address_i, .h1_a_mask_i, .h1_a_data_i, .h1_a_ready_o,
    .h1_d_valid_o, .h1_d_opcode_o, .h1_d_size_o, .h1_d_source_o,
    .h1_d_data_o, .h1_d_ready_i,
    .dev_a_valid_o   (dev_a_valid),
    .dev_a_opcode_o  (dev_a_opcode),
    .dev_a_size_o    (dev_a_size),
    .dev_a_source_o  (dev_a_source),
    .dev_a_address_o (dev_a_address),
    .dev_a_mask_o    (dev_a_mask),
    .dev_a_data_o    (dev_a_data),
    .dev_a_ready_i   (dev_a_ready),
    .dev_d_valid_i   (dev_d_valid),
    .dev_d_opcode_i  (dev_d_opcode),
    .dev_d_size_i    (dev_d_size),
    .dev_d_source_i  (dev_d_source),
    .dev_d_data_i    (dev_d_data),
    .dev_d_ready_o   (dev_d_ready)
  );

  tl_adapter_bram u_adapter (
    .clk_i, .rst_ni,
    .a_valid_i    (dev_a_valid),
    .a_opcode_i   (dev_a_opcode),
    .a_size_i     (dev_a_size),
    .a_source_i   (dev_a_source),
    .a_address_i  (dev_a_address),
    .a_mask_i     (dev_a_mask),
    .a_data_i     (dev_a_data),
    .a_ready_o    (dev_a_ready),
    .d_valid_o    (dev_d_valid),
    .d_opcode_o   (dev_d_opcode),
    .d_size_o     (dev_d_size),
    .d_source_o   (dev_d_source),
    .d_data_o     (dev_d_data),
    .d_ready_i    (dev_d_ready),
    .bram_en_o    (bram_en),
    .bram_we_o    (bram_we),
    .bram_addr_o  (bram_addr),
    .bram_wmask_o (bram_wmask),
    .bram_wdata_o (bram_wdata),
    .bram_rdata_i (bram_rdata)
  );

  bram_sp u_ram (
    .clk_i,
    .en_i    (bram_en),
    .we_i    (bram_we),
    .addr_i  (bram_addr),
    .wmask_i (bram_wmask),
    .wdata_i (bram_wdata),
    .rdata_o (bram_rdata)
  );

endmodule

`default_nettype wire

// File: verif/tb_tl_mem.sv
// Testbench for tl_mem_top with stimulus table, reference memory, D monitor and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_tl_mem;

  typedef struct packed {
    bit                 host;
    tl_pkg::tl_a_op_e   op;
    logic [3:0]         src;
    logic [31:0]        addr;
    logic [3:0]         mask;
    logic [31:0]        data;
    bit                 conc;
    bit                 rnd;
  } entry_t;

  typedef struct packed {
    tl_pkg::tl_d_op_e   op;
    logic [3:0]         src;
    logic [31:0]        data;
  } exp_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic h0_a_valid_i, h0_a_ready_o, h0_d_valid_o, h0_d_ready_i;
  logic h1_a_valid_i, h1_a_ready_o, h1_d_valid_o, h1_d_ready_i;
  tl_pkg::tl_a_op_e h0_a_opcode_i, h1_a_opcode_i;
  tl_pkg::tl_d_op_e h0_d_opcode_o, h1_d_opcode_o;
  logic [2:0]  h0_a_size_i, h1_a_size_i, h0_d_size_o, h1_d_size_o;
  logic [3:0]  h0_a_source_i, h1_a_source_i, h0_d_source_o, h1_d_source_o;
  logic [31:0] h0_a_address_i, h1_a_address_i;
  logic [3:0]  h0_a_mask_i, h1_a_mask_i;
  logic [31:0] h0_a_data_i, h1_a_data_i, h0_d_data_o, h1_d_data_o;

  entry_t      table_q[$];
  exp_t        exp_q0[$];
  exp_t        exp_q1[$];
  logic [31:0] ref_mem [int];
  bit          last_model = 1'b1;
  bit          rand_ready = 1'b0;
  int unsigned errors = 0;
  bit          stall_q [2];
  logic [41:0] prev_pay [2];

  tl_mem_top u_tl_mem_top (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic void add(bit host, tl_pkg::tl_a_op_e op, logic [3:0] src,
                              logic [31:0] addr, logic [3:0] mask, logic [31:0] data,
                              bit conc, bit rnd);
    entry_t e;
    e = '{host, op, src, addr, mask, data, conc, rnd};
    table_q.push_back(e);
  endfunction

  function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] data, logic [3:0] mask);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  // Reference model: apply one request in grant order, queue its response
  function automatic void model_request(entry_t e);
    exp_t ex;
    int   idx;
    idx = int'(e.addr[11:2]);
    if (e.op == tl_pkg::Get) begin
      ex = '{tl_pkg::AccessAckData, e.src, ref_mem[idx]};
    end else begin
      ref_mem[idx] = merge(ref_mem.exists(idx) ? ref_mem[idx] : 32'h0, e.data, e.mask);
      ex = '{tl_pkg::AccessAck, e.src, 32'h0};
    end
    if (e.host) exp_q1.push_back(ex);
    else exp_q0.push_back(ex);
    last_model = e.host;
  endfunction

  task automatic drive_a(input bit host, input logic vld, input entry_t e);
    if (host == 1'b0) begin
      h0_a_valid_i   <= vld;
      h0_a_opcode_i  <= e.op;
      h0_a_size_i    <= 3'd2;
      h0_a_source_i  <= e.src;
      h0_a_address_i <= e.addr;
      h0_a_mask_i    <= e.mask;
      h0_a_data_i    <= e.data;
    end else begin
      h1_a_valid_i   <= vld;
      h1_a_opcode_i  <= e.op;
      h1_a_size_i    <= 3'd2;
      h1_a_source_i  <= e.src;
      h1_a_address_i <= e.addr;
      h1_a_mask_i    <= e.mask;
      h1_a_data_i    <= e.data;
    end
  endtask

  // Holds valid until the A transfer, optionally checks one-cycle latency
  task automatic issue(input entry_t e, input bit check_lat, output time fire_t);
    @(posedge clk_i);
    drive_a(e.host, 1'b1, e);
    do @(negedge clk_i); while (!(e.host ? h1_a_ready_o : h0_a_ready_o));
    fire_t = $time;
    @(posedge clk_i);
    drive_a(e.host, 1'b0, e);
    if (check_lat) begin
      @(negedge clk_i);
      assert (e.host ? h1_d_valid_o : h0_d_valid_o)
      else begin
        $display("Error at %0t: response not one cycle after A transfer", $time);
        errors++;
      end
    end
  endtask

  ////////////////////////////////////////
  // D channel monitor
  ////////////////////////////////////////

  task automatic check_d(input bit host);
    logic        v;
    logic        r;
    logic [41:0] pay;
    exp_t        ex;
    v   = host ? h1_d_valid_o : h0_d_valid_o;
    r   = host ? h1_d_ready_i : h0_d_ready_i;
    pay = host ? {h1_d_opcode_o, h1_d_size_o, h1_d_source_o, h1_d_data_o}
               : {h0_d_opcode_o, h0_d_size_o, h0_d_source_o, h0_d_data_o};
    if (stall_q[host]) begin
      assert (v && pay == prev_pay[host])
      else begin
        $display("Error at %0t: host %0d response changed under back-pressure", $time, host);
        errors++;
      end
    end
    if (v && !r) begin
      assert (!h0_a_ready_o && !h1_a_ready_o)
      else begin
        $display("Error at %0t: a_ready high while host %0d stalls D", $time, host);
        errors++;
      end
    end
    stall_q[host]  = v && !r;
    prev_pay[host] = pay;
    if (v && r) begin
      assert ((host ? exp_q1.size() : exp_q0.size()) != 0)
      else begin
        $display("Host %0d received a response that no request asked for", host);
        errors++;
      end
      if ((host ? exp_q1.size() : exp_q0.size()) != 0) begin
        ex = host ? exp_q1.pop_front() : exp_q0.pop_front();
        assert (pay[41:39] == ex.op && pay[38:36] == 3'd2 && pay[35:32] == ex.src &&
                (ex.op == tl_pkg::AccessAck || pay[31:0] == ex.data))
        else begin
          $display("Error at %0t: host %0d got op %0d src %0h data %h, expected %0d %0h %h",
                   $time, host, pay[41:39], pay[35:32], pay[31:0], ex.op, ex.src, ex.data);
          errors++;
        end
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_d(1'b0);
      check_d(1'b1);
    end
  end

  // Back-pressure source, random in the later part of the table
  always @(posedge clk_i) begin
    h0_d_ready_i <= rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    h1_d_ready_i <= rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    entry_t      a;
    entry_t      b;
    entry_t      first;
    time         ta;
    time         tb;
    int unsigned err_before;
    int unsigned i;
    void'($urandom(32'h3f58));
    rst_ni = 1'b0;
    drive_a(1'b0, 1'b0, '0);
    drive_a(1'b1, 1'b0, '0);
    h0_d_ready_i = 1'b1;
    h1_d_ready_i = 1'b1;

    // Tie straight after reset goes to host 0
    add(1, tl_pkg::PutFullData,    4'h1, 32'h100, 4'hf, 32'h5555_aaaa, 1, 0);
    add(0, tl_pkg::PutFullData,    4'h7, 32'h100, 4'hf, 32'h3c3c_c3c3, 0, 0);
    add(0, tl_pkg::Get,            4'h5, 32'h100, 4'hf, 32'h0,         0, 0);
    add(0, tl_pkg::PutFullData,    4'h3, 32'h10, 4'hf, 32'h1122_3344, 0, 0);
    add(0, tl_pkg::Get,            4'h4, 32'h10, 4'hf, 32'h0,         0, 0);
    add(1, tl_pkg::PutFullData,    4'h5, 32'h20, 4'hf, 32'ha5a5_a5a5, 0, 0);
    add(1, tl_pkg::PutPartialData, 4'h6, 32'h20, 4'h5, 32'h1234_5678, 0, 0);
    add(1, tl_pkg::Get,            4'h7, 32'h20, 4'hf, 32'h0,         0, 0);
    add(0, tl_pkg::Get,            4'h1, 32'h20, 4'hf, 32'h0,         0, 0);
    add(0, tl_pkg::PutFullData,    4'h2, 32'h40, 4'hf, 32'hdead_beef, 1, 0);
    add(1, tl_pkg::PutFullData,    4'h9, 32'h40, 4'hf, 32'hcafe_f00d, 0, 0);
    add(0, tl_pkg::Get,            4'ha, 32'h40, 4'hf, 32'h0,         0, 0);
    add(0, tl_pkg::Get,            4'hb, 32'h10, 4'hf, 32'h0,         1, 0);
    add(1, tl_pkg::Get,            4'hc, 32'h20, 4'hf, 32'h0,         0, 0);
    add(1, tl_pkg::PutPartialData, 4'hd, 32'h40, 4'hc, 32'h7788_0000, 1, 1);
    add(0, tl_pkg::Get,            4'he, 32'h40, 4'hf, 32'h0,         0, 1);
    add(0, tl_pkg::PutFullData,    4'h0, 32'h80, 4'hf, 32'h0bad_c0de, 0, 1);
    add(1, tl_pkg::Get,            4'h8, 32'h80, 4'hf, 32'h0,         0, 1);
    add(0, tl_pkg::PutPartialData, 4'hf, 32'h80, 4'h2, 32'h0000_5500, 1, 1);
    add(1, tl_pkg::Get,            4'h1, 32'h80, 4'hf, 32'h0,         0, 1);
    add(0, tl_pkg::Get,            4'h2, 32'h80, 4'hf, 32'h0,         0, 1);

    // Watchdog sized from the table length plus reset
    fork
      begin
        #((table_q.size() * 20 + 5) * 20);
        $display("Timeout: the DUT did not finish all requests in time");
        $display("test failed");
        $finish;
      end
    join_none

    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    i = 0;
    while (i < table_q.size()) begin
      err_before = errors;
      a = table_q[i];
      rand_ready = a.rnd;
      if (a.conc) begin
        b = table_q[i+1];
        // The host that did not win last takes the tie
        first = (a.host == !last_model) ? a : b;
        model_request(first);
        model_request(first.host == a.host ? b : a);
        fork
          issue(a, 1'b0, ta);
          issue(b, 1'b0, tb);
        join
        assert ((first.host == a.host) ? (ta < tb) : (tb < ta))
        else begin
          $display("Error at %0t: tie between entries %0d and %0d granted out of turn",
                   $time, i, i + 1);
          errors++;
        end
        $display("Entries %0d and %0d: concurrent pair done, %0d new errors",
                 i, i + 1, errors - err_before);
        i += 2;
      end else begin
        model_request(a);
        issue(a, !a.rnd, ta);
        $display("Entry %0d: host %0d opcode %0d done, %0d new errors",
                 i, a.host, a.op, errors - err_before);
        i += 1;
      end
    end

    while (exp_q0.size() != 0 || exp_q1.size() != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i);

    $display("Tests run: %0d entries, errors: %0d", table_q.size(), errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
common/tl_pkg.sv
hw/bram_sp.sv
hw/tl_adapter_bram.sv
hw/tl_host_arb.sv
hw/tl_mem_top.sv
verif/tb_tl_mem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_tl_mem
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "test passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
